//--- hw/demosaic_pkg.sv
`default_nettype none

package demosaic_pkg;

    // image geometry
    localparam int img_width   = 128;
    localparam int img_height  = 128;
    localparam int pixel_count = img_width * img_height;  // 16384 sites

    localparam int pixel_w = 8;
    localparam int addr_w  = 14;  // covers pixel_count exactly

    // green interpolation
    localparam int neighbor_count = 4;  // up, left, right, down
    localparam int avg_shift      = 2;  // divide by four

    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic [addr_w-1:0]  addr_t;

    // colour of a Bayer site
    typedef enum logic [1:0] {
        color_green = 2'd0,  // row + col even
        color_red   = 2'd1,  // even row, odd col
        color_blue  = 2'd2   // odd row, even col
    } bayer_color_e;

    // controller phase
    typedef enum logic [1:0] {
        st_raw   = 2'd0,  // raw stream lands in memory
        st_green = 2'd1,  // interpolator owns green memory
        st_done  = 2'd2
    } demosaic_state_e;

endpackage

`default_nettype wire

//--- hw/mem_port_if.sv
`default_nettype none

// one colour memory port, read data is combinational from addr
interface mem_port_if;
    import demosaic_pkg::*;

    logic   wr;     // single cycle write strobe
    addr_t  addr;
    pixel_t wdata;
    pixel_t rdata;  // word at addr, same cycle

    modport master (
        output wr,
        output addr,
        output wdata,
        input  rdata
    );

    modport mem (
        input  wr,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- hw/bayer_writer.sv
`default_nettype none

module bayer_writer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_en,
    input  demosaic_pkg::pixel_t data_in,
    mem_port_if.master           r_port,
    mem_port_if.master           g_port,
    mem_port_if.master           b_port,
    output logic                 raw_last
);
    import demosaic_pkg::*;

    addr_t        pix_cnt;     // raster index of next pixel
    logic         frame_full;  // all pixels taken
    logic         accept;
    logic         row_odd;
    logic         col_odd;
    bayer_color_e site_color;
    logic         wr_r;
    logic         wr_g;
    logic         wr_b;
    addr_t        wr_addr;
    pixel_t       wr_data;

    assign accept  = in_en && !frame_full;
    assign row_odd = ((pix_cnt / img_width) % 2) != 0;
    assign col_odd = (pix_cnt % 2) != 0;

    always_comb begin
        if (row_odd == col_odd) begin
            site_color = color_green;
        end else if (col_odd) begin
            site_color = color_red;  // even row
        end else begin
            site_color = color_blue;  // odd row
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_cnt    <= '0;
            frame_full <= 1'b0;
        end else if (accept) begin
            if (pix_cnt == addr_t'(pixel_count - 1)) begin
                frame_full <= 1'b1;  // hold, later strobes dropped
            end else begin
                pix_cnt <= pix_cnt + addr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_r     <= 1'b0;
            wr_g     <= 1'b0;
            wr_b     <= 1'b0;
            raw_last <= 1'b0;
        end else begin
            wr_r     <= accept && (site_color == color_red);
            wr_g     <= accept && (site_color == color_green);
            wr_b     <= accept && (site_color == color_blue);
            raw_last <= accept && (pix_cnt == addr_t'(pixel_count - 1));
        end
    end

    // shared payload, only one strobe is ever high
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr <= pix_cnt;
            wr_data <= data_in;
        end
    end

    assign r_port.wr    = wr_r;
    assign r_port.addr  = wr_addr;
    assign r_port.wdata = wr_data;
    assign g_port.wr    = wr_g;
    assign g_port.addr  = wr_addr;
    assign g_port.wdata = wr_data;
    assign b_port.wr    = wr_b;
    assign b_port.addr  = wr_addr;
    assign b_port.wdata = wr_data;

    a_one_colour: assert property (@(posedge clk) disable iff (reset)
        $onehot0({r_port.wr, g_port.wr, b_port.wr}));

endmodule

`default_nettype wire

//--- hw/green_interp.sv
`default_nettype none

module green_interp (
    input  logic       clk,
    input  logic       reset,
    input  logic       interp_start,
    mem_port_if.master g_port,
    output logic       interp_last
);
    import demosaic_pkg::*;

    logic       active;
    logic [2:0] step;       // 0..3 read, 4 write
    logic [9:0] acc;        // sum of four neighbours
    addr_t      site;       // current red or blue site
    addr_t      next_site;
    addr_t      nb_addr;
    logic       write_step;
    logic       last_site;

    assign write_step = active && (step == 3'(neighbor_count));
    assign last_site  = site == addr_t'(pixel_count - 2);  // row 127, col 126

    // neighbour address, 14-bit arithmetic wraps the frame
    always_comb begin
        case (step)
            3'd0:    nb_addr = site - addr_t'(img_width);  // up
            3'd1:    nb_addr = site - addr_t'(1);          // left
            3'd2:    nb_addr = site + addr_t'(1);          // right
            3'd3:    nb_addr = site + addr_t'(img_width);  // down
            default: nb_addr = site;                       // write back
        endcase
    end

    // skip green sites, row parity flips at each row end
    always_comb begin
        if ((site % img_width) == img_width - 1) begin
            next_site = site + addr_t'(1);  // even row end, to col 0 below
        end else if ((site % img_width) == img_width - 2) begin
            next_site = site + addr_t'(3);  // odd row end, to col 1 below
        end else begin
            next_site = site + addr_t'(2);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            step   <= '0;
            site   <= addr_t'(1);
        end else if (!active) begin
            if (interp_start) begin
                active <= 1'b1;
                step   <= '0;
                site   <= addr_t'(1);  // first red site
            end
        end else if (write_step) begin
            step <= '0;
            site <= next_site;
            if (last_site) begin
                active <= 1'b0;
            end
        end else begin
            step <= step + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            if (step == 3'd0) begin
                acc <= 10'(g_port.rdata);
            end else if (!write_step) begin
                acc <= acc + 10'(g_port.rdata);
            end
        end
    end

    assign g_port.wr    = write_step;
    assign g_port.addr  = nb_addr;
    assign g_port.wdata = pixel_t'(acc >> avg_shift);
    assign interp_last  = write_step && last_site;

    // writes land only on red or blue sites, row and column parity differ
    a_write_site: assert property (@(posedge clk) disable iff (reset)
        g_port.wr |-> ((g_port.addr / img_width) % 2) != (g_port.addr % 2));

endmodule

`default_nettype wire

//--- hw/demosaic_ctrl.sv
`default_nettype none

module demosaic_ctrl (
    input  logic       clk,
    input  logic       reset,
    input  logic       raw_last,
    input  logic       interp_last,
    mem_port_if.mem    raw_g_port,
    mem_port_if.mem    interp_g_port,
    mem_port_if.master ext_g_port,
    output logic       interp_start,
    output logic       done
);
    import demosaic_pkg::*;

    demosaic_state_e state;
    demosaic_state_e state_next;
    logic            sel_interp;  // interpolator owns green memory

    always_comb begin
        state_next = state;
        case (state)
            st_raw: begin
                if (raw_last) begin
                    state_next = st_green;
                end
            end
            st_green: begin
                if (interp_last) begin
                    state_next = st_done;
                end
            end
            default: state_next = st_done;  // stay until reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_raw;
            interp_start <= 1'b0;
            done         <= 1'b0;
        end else begin
            state        <= state_next;
            interp_start <= (state == st_raw) && raw_last;
            done         <= state_next == st_done;
        end
    end

    assign sel_interp = state != st_raw;

    assign ext_g_port.wr    = sel_interp ? interp_g_port.wr    : raw_g_port.wr;
    assign ext_g_port.addr  = sel_interp ? interp_g_port.addr  : raw_g_port.addr;
    assign ext_g_port.wdata = sel_interp ? interp_g_port.wdata : raw_g_port.wdata;

    // read data goes back to both sides
    assign raw_g_port.rdata    = ext_g_port.rdata;
    assign interp_g_port.rdata = ext_g_port.rdata;

    a_done_sticky: assert property (@(posedge clk) disable iff (reset)
        done |=> done);

endmodule

`default_nettype wire

//--- hw/demosaic_top.sv
`default_nettype none

module demosaic_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_en,
    input  demosaic_pkg::pixel_t data_in,
    output logic                 wr_r,
    output demosaic_pkg::addr_t  addr_r,
    output demosaic_pkg::pixel_t wdata_r,
    input  demosaic_pkg::pixel_t rdata_r,
    output logic                 wr_g,
    output demosaic_pkg::addr_t  addr_g,
    output demosaic_pkg::pixel_t wdata_g,
    input  demosaic_pkg::pixel_t rdata_g,
    output logic                 wr_b,
    output demosaic_pkg::addr_t  addr_b,
    output demosaic_pkg::pixel_t wdata_b,
    input  demosaic_pkg::pixel_t rdata_b,
    output logic                 done
);

    logic raw_last;
    logic interp_start;
    logic interp_last;

    mem_port_if raw_r_port ();
    mem_port_if raw_g_port ();
    mem_port_if raw_b_port ();
    mem_port_if interp_g_port ();
    mem_port_if ext_g_port ();  // green memory after the mux

    bayer_writer u_writer (
        .clk      (clk),
        .reset    (reset),
        .in_en    (in_en),
        .data_in  (data_in),
        .r_port   (raw_r_port.master),
        .g_port   (raw_g_port.master),
        .b_port   (raw_b_port.master),
        .raw_last (raw_last)
    );

    green_interp u_interp (
        .clk          (clk),
        .reset        (reset),
        .interp_start (interp_start),
        .g_port       (interp_g_port.master),
        .interp_last  (interp_last)
    );

    demosaic_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .raw_last      (raw_last),
        .interp_last   (interp_last),
        .raw_g_port    (raw_g_port.mem),
        .interp_g_port (interp_g_port.mem),
        .ext_g_port    (ext_g_port.master),
        .interp_start  (interp_start),
        .done          (done)
    );

    assign wr_r             = raw_r_port.wr;
    assign addr_r           = raw_r_port.addr;
    assign wdata_r          = raw_r_port.wdata;
    assign raw_r_port.rdata = rdata_r;

    assign wr_g             = ext_g_port.wr;
    assign addr_g           = ext_g_port.addr;
    assign wdata_g          = ext_g_port.wdata;
    assign ext_g_port.rdata = rdata_g;

    assign wr_b             = raw_b_port.wr;
    assign addr_b           = raw_b_port.addr;
    assign wdata_b          = raw_b_port.wdata;
    assign raw_b_port.rdata = rdata_b;

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period  = 20;  // 40 ns clock
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/pixel_mem.sv
`default_nettype none

module pixel_mem (
    input  logic                 clk,
    input  logic                 wr,
    input  demosaic_pkg::addr_t  addr,
    input  demosaic_pkg::pixel_t wdata,
    output demosaic_pkg::pixel_t rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    import demosaic_pkg::*;

    pixel_t mem [pixel_count];

    // fill mixes low and high address bits so a stray address shows up
    initial begin
        for (int i = 0; i < pixel_count; i++) begin
            mem[i] <= pixel_t'((i * 29) ^ (i >> 7));
        end
    end

    always @(posedge clk) begin
        if (wr === 1'b1) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];  // combinational read

endmodule

`default_nettype wire

//--- dv/tb_demosaic.sv
`default_nettype none

module tb_demosaic;
    timeunit 1ns;
    timeprecision 100ps;

    import demosaic_pkg::*;

    localparam int done_latency = (pixel_count / 2) * 5 + 2;  // last raw write to done
    localparam int gap_every    = 8;   // a gap may follow every 8th pixel
    localparam int gap_max      = 3;
    localparam int cycle_limit  = 16 + pixel_count + (pixel_count / gap_every) * gap_max
                                  + done_latency + 600;  // about 64000
    localparam int max_reports  = 8;

    logic   clk;
    logic   reset;
    logic   in_en;
    pixel_t data_in;
    logic   wr_r;
    logic   wr_g;
    logic   wr_b;
    addr_t  addr_r;
    addr_t  addr_g;
    addr_t  addr_b;
    pixel_t wdata_r;
    pixel_t wdata_g;
    pixel_t wdata_b;
    pixel_t rdata_r;
    pixel_t rdata_g;
    pixel_t rdata_b;
    logic   done;

    pixel_t pixels [pixel_count];  // streamed image
    pixel_t exp_r [pixel_count];
    pixel_t exp_g [pixel_count];
    pixel_t exp_b [pixel_count];
    integer seed;
    int     checks = 0;
    int     errors = 0;
    int     test_errors = 0;
    int     tests_run = 0;
    int     timeout_count;

    // monitor results, sampled on the falling edge
    logic counting = 1'b0;  // raw stream window
    int   neg_cycle = 0;
    int   raw_writes = 0;
    int   double_strobes = 0;
    int   last_raw_cycle = -1;
    int   green_writes = 0;
    int   done_cycle = -1;
    int   late_writes = 0;

    clk_gen clk0 (.clk(clk), .reset(reset));

    demosaic_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .in_en   (in_en),
        .data_in (data_in),
        .wr_r    (wr_r),
        .addr_r  (addr_r),
        .wdata_r (wdata_r),
        .rdata_r (rdata_r),
        .wr_g    (wr_g),
        .addr_g  (addr_g),
        .wdata_g (wdata_g),
        .rdata_g (rdata_g),
        .wr_b    (wr_b),
        .addr_b  (addr_b),
        .wdata_b (wdata_b),
        .rdata_b (rdata_b),
        .done    (done)
    );

    pixel_mem mem_r (.clk(clk), .wr(wr_r), .addr(addr_r), .wdata(wdata_r), .rdata(rdata_r));
    pixel_mem mem_g (.clk(clk), .wr(wr_g), .addr(addr_g), .wdata(wdata_g), .rdata(rdata_g));
    pixel_mem mem_b (.clk(clk), .wr(wr_b), .addr(addr_b), .wdata(wdata_b), .rdata(rdata_b));

    always @(negedge clk) begin
        int strobes;
        strobes = int'(wr_r === 1'b1) + int'(wr_g === 1'b1) + int'(wr_b === 1'b1);
        neg_cycle++;
        if (counting) begin
            raw_writes += strobes;
            if (strobes > 1) begin
                double_strobes++;
            end
            if (strobes > 0) begin
                last_raw_cycle = neg_cycle;
            end
        end else if (done === 1'b1) begin
            late_writes += strobes;
        end else begin
            green_writes += int'(wr_g === 1'b1);
        end
        if (done === 1'b1 && done_cycle < 0) begin
            done_cycle = neg_cycle;
        end
    end

    initial begin
        timeout_count = 0;
        while (timeout_count < cycle_limit) begin
            @(posedge clk);
            timeout_count++;
        end
        $display("timeout: no result after %0d cycles, done is %b", cycle_limit, done);
        $display("CHECKS FAILED");
        $finish;
    end

    // bayer rule, green where row + col is even
    function automatic bayer_color_e color_of(int idx);
        int row;
        int col;
        row = idx / img_width;
        col = idx % img_width;
        if ((row + col) % 2 == 0) begin
            return color_green;
        end else if (row % 2 == 0) begin
            return color_red;
        end
        return color_blue;
    endfunction

    function automatic int wrap(int idx);
        return (idx + pixel_count) % pixel_count;
    endfunction

    task automatic report_error(string msg);
        errors++;
        test_errors++;
        if (test_errors <= max_reports) begin
            $display("error at %0d ns: %s", $time, msg);
        end
    endtask

    task automatic start_test();
        test_errors = 0;
        tests_run++;
    endtask

    task automatic close_test(string name);
        if (test_errors > max_reports) begin
            $display("  %0d more errors in %s not shown", test_errors - max_reports, name);
        end
        $display("test %s finished with %0d errors", name, test_errors);
    endtask

    task automatic check_word(string mem_name, int idx, pixel_t got, pixel_t want);
        checks++;
        if (got !== want) begin
            report_error($sformatf("%s memory at %0d holds %02h, expected %02h",
                                   mem_name, idx, got, want));
        end
    endtask

    task automatic test_reset_state();
        start_test();
        repeat (4) begin
            @(negedge clk);
            checks++;
            if ({wr_r, wr_g, wr_b, done} !== 4'b0000) begin
                report_error($sformatf("after reset wr_r %b wr_g %b wr_b %b done %b",
                                       wr_r, wr_g, wr_b, done));
            end
        end
        close_test("reset_state");
    endtask

    task automatic test_raw_distribution();
        int gap;
        start_test();
        @(posedge clk);
        counting = 1'b1;
        for (int i = 0; i < pixel_count; i++) begin
            @(negedge clk);
            in_en     = 1'b1;
            data_in   = pixel_t'($random(seed));
            pixels[i] = data_in;
            if (i % gap_every == gap_every - 1 && i != pixel_count - 1) begin
                gap = $unsigned($random(seed)) % (gap_max + 1);
                repeat (gap) begin
                    @(negedge clk);
                    in_en = 1'b0;
                end
            end
        end
        @(negedge clk);
        in_en = 1'b0;
        repeat (3) @(negedge clk);
        @(posedge clk);
        counting = 1'b0;  // closes before the first green write
        for (int i = 0; i < pixel_count; i++) begin
            case (color_of(i))
                color_red:  check_word("red", i, mem_r.mem[i], pixels[i]);
                color_blue: check_word("blue", i, mem_b.mem[i], pixels[i]);
                default:    check_word("green", i, mem_g.mem[i], pixels[i]);
            endcase
        end
        close_test("raw_distribution");
    endtask

    task automatic test_write_count();
        start_test();
        checks++;
        if (raw_writes != pixel_count) begin
            report_error($sformatf("%0d raw writes, expected %0d", raw_writes, pixel_count));
        end
        checks++;
        if (double_strobes != 0) begin
            report_error($sformatf("%0d cycles with two write strobes", double_strobes));
        end
        close_test("write_count");
    endtask

    task automatic test_green_interp();
        int sum;
        start_test();
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        for (int i = 0; i < pixel_count; i++) begin
            case (color_of(i))
                color_red:  exp_r[i] = pixels[i];
                color_blue: exp_b[i] = pixels[i];
                default:    exp_g[i] = pixels[i];
            endcase
        end
        // in place, ascending, so a wrapped neighbour may already hold its average
        for (int i = 0; i < pixel_count; i++) begin
            if (color_of(i) != color_green) begin
                sum = int'(exp_g[wrap(i - img_width)]) + int'(exp_g[wrap(i - 1)])
                      + int'(exp_g[wrap(i + 1)]) + int'(exp_g[wrap(i + img_width)]);
                exp_g[i] = pixel_t'(sum / 4);
            end
        end
        for (int i = 0; i < pixel_count; i++) begin
            check_word("green", i, mem_g.mem[i], exp_g[i]);
            check_word("red", i, mem_r.mem[i], exp_r[i]);
            check_word("blue", i, mem_b.mem[i], exp_b[i]);
        end
        checks++;
        if (green_writes != pixel_count / 2) begin
            report_error($sformatf("%0d green writes, expected %0d",
                                   green_writes, pixel_count / 2));
        end
        close_test("green_interp");
    endtask

    task automatic test_done_timing();
        start_test();
        checks++;
        if (done_cycle - last_raw_cycle != done_latency) begin
            report_error($sformatf("done rose %0d cycles after the last raw write, expected %0d",
                                   done_cycle - last_raw_cycle, done_latency));
        end
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            in_en   = 1'b1;  // beyond the frame, must be ignored
            data_in = pixel_t'($random(seed));
            checks++;
            if (done !== 1'b1) begin
                report_error("done dropped after the frame completed");
            end
        end
        @(negedge clk);
        in_en = 1'b0;
        repeat (3) @(negedge clk);
        @(posedge clk);
        checks++;
        if (late_writes != 0) begin
            report_error($sformatf("%0d writes after done", late_writes));
        end
        close_test("done_timing");
    endtask

    initial begin
        in_en   = 1'b0;
        data_in = '0;
        seed    = 32'h7e81;
        @(posedge clk);
        while (reset !== 1'b0) begin
            @(posedge clk);
        end
        for (int i = 0; i < pixel_count; i++) begin
            exp_r[i] = mem_r.mem[i];  // fill pattern, untouched so far
            exp_g[i] = mem_g.mem[i];
            exp_b[i] = mem_b.mem[i];
        end
        test_reset_state();
        test_raw_distribution();
        test_write_count();
        test_green_interp();
        test_done_timing();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hw/demosaic_pkg.sv
hw/mem_port_if.sv
hw/bayer_writer.sv
hw/green_interp.sv
hw/demosaic_ctrl.sv
hw/demosaic_top.sv
dv/clk_gen.sv
dv/pixel_mem.sv
dv/tb_demosaic.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_demosaic \
    -o tb_demosaic > build.log 2>&1 \
    && ./obj_dir/tb_demosaic > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
